/* source/dataFrameGenerator.sv */
module dataFrameGenerator (
  input  logic                           WR_CLK,
  input  logic                           RD_RESET,
  input  logic [framePkg::PRE_LEN_W-1:0] preLen,
  input  logic                           inValid,
  input  framePkg::sampleBeat            inBeat,
  output logic                           inReady,
  input  logic                           outReady,
  output logic                           outValid,
  output framePkg::frameWord             outWord
);

  wire beatAccept = inValid & inReady;     // handshake on the input stream

  framePkg::sampleBeat delayedBeat;
  logic delayedValid;
  logic wrReq;
  framePkg::ramReq wrData;
  logic descPush;
  framePkg::frameInfo descIn;
  logic descFull;
  logic descValid;
  framePkg::frameInfo descOut;
  logic descPop;
  logic slotFree;
  logic rdReq;
  logic [3:0] rdAddr;
  logic rdGrant;
  logic rdValid;
  framePkg::frameWord rdData;
  logic outPush;
  framePkg::frameWord pushWord;
  logic [framePkg::OUT_CNT_W-1:0] outFree;

  preTriggerDelay delayLine (
    .WR_CLK (WR_CLK), .RD_RESET (RD_RESET), .beatValid (beatAccept), .beatIn (inBeat),
    .preLen (preLen), .delayedBeat (delayedBeat), .delayedValid (delayedValid)
  );

  frameCapture capture (
    .WR_CLK (WR_CLK), .RD_RESET (RD_RESET), .beatValid (beatAccept), .beatIn (inBeat),
    .delayedBeat (delayedBeat), .delayedValid (delayedValid), .preLen (preLen),
    .inReady (inReady), .wrReq (wrReq), .wrData (wrData), .descPush (descPush),
    .desc (descIn), .descFull (descFull), .slotFree (slotFree)
  );

  syncFifo #(.payload_t (framePkg::frameInfo), .DEPTH (framePkg::DESC_DEPTH)) descQueue (
    .WR_CLK (WR_CLK), .RD_RESET (RD_RESET), .push (descPush), .din (descIn),
    .pop (descPop), .dout (descOut), .notEmpty (descValid), .full (descFull),
    .freeCount ()
  );

  frameRamArbiter arbiter (
    .WR_CLK (WR_CLK), .RD_RESET (RD_RESET), .wrReq (wrReq), .wrData (wrData),
    .rdReq (rdReq), .rdAddr (rdAddr), .rdGrant (rdGrant), .rdValid (rdValid),
    .rdData (rdData)
  );

  frameReader reader (
    .WR_CLK (WR_CLK), .RD_RESET (RD_RESET), .descValid (descValid), .desc (descOut),
    .descPop (descPop), .rdReq (rdReq), .rdAddr (rdAddr), .rdGrant (rdGrant),
    .rdValid (rdValid), .rdData (rdData), .outPush (outPush), .outWord (pushWord),
    .outFree (outFree), .slotFree (slotFree)
  );

  // output words, popped straight by the sink handshake
  syncFifo #(.payload_t (framePkg::frameWord), .DEPTH (framePkg::OUT_DEPTH)) outQueue (
    .WR_CLK (WR_CLK), .RD_RESET (RD_RESET), .push (outPush), .din (pushWord),
    .pop (outReady), .dout (outWord), .notEmpty (outValid), .full (),
    .freeCount (outFree)
  );

endmodule

/* source/frameCapture.sv */
module frameCapture (
  input  logic                           WR_CLK,
  input  logic                           RD_RESET,
  input  logic                           beatValid,
  input  framePkg::sampleBeat            beatIn,
  input  framePkg::sampleBeat            delayedBeat,
  input  logic                           delayedValid,
  input  logic [framePkg::PRE_LEN_W-1:0] preLen,
  output logic                           inReady,
  output logic                           wrReq,
  output framePkg::ramReq                wrData,
  output logic                           descPush,
  output framePkg::frameInfo             desc,
  input  logic                           descFull,
  input  logic                           slotFree
);

  logic readyReg;                          // low through reset
  logic [framePkg::TS_W-1:0] tsCnt;        // timestamp of the live beat
  logic [15:0] seqCnt;
  logic [1:0] slotBusy;
  logic nextSlot;                          // slots are taken in turn
  logic freeSlot;                          // and freed in the same order
  logic capturing;
  logic [3:0] beatCnt;                     // delayed beats taken so far
  logic curSlot;
  logic [framePkg::PRE_LEN_W-1:0] framePre;
  logic [framePkg::TS_W-1:0] frameTs;
  framePkg::sampleBeat holdBeat;           // earlier beat of a pair
  framePkg::dataWord packed2;
  logic start;
  logic lastWrite;

  // busy slots form a run, so a busy nextSlot means both are taken
  assign start = beatValid & beatIn.trig & ~capturing & ~slotBusy[nextSlot] & ~descFull;

  assign wrReq     = capturing & delayedValid & beatCnt[0];   // odd beat closes a word
  assign lastWrite = wrReq & (beatCnt == 4'(framePkg::FRAME_BEATS - 1));
  assign inReady   = readyReg;

  assign packed2 = '{pad: 16'd0,
                     earlyA: holdBeat.sampleA, earlyB: holdBeat.sampleB,
                     lateA: delayedBeat.sampleA, lateB: delayedBeat.sampleB};
  assign wrData  = '{write: 1'b1, addr: {curSlot, beatCnt[3:1]}, wdata: packed2};

  assign desc = '{timeStamp: frameTs, seqNum: seqCnt, preLen: framePre, slot: curSlot};

  always_ff @(posedge WR_CLK) begin
    if (RD_RESET) begin
      readyReg  <= 1'b0;
      tsCnt     <= '0;
      seqCnt    <= '0;
      slotBusy  <= '0;
      nextSlot  <= 1'b0;
      freeSlot  <= 1'b0;
      capturing <= 1'b0;
      beatCnt   <= '0;
      descPush  <= 1'b0;
    end else begin
      readyReg <= 1'b1;
      descPush <= lastWrite;               // push the cycle after the last write
      if (beatValid) tsCnt <= tsCnt + 1'b1;
      if (descPush) seqCnt <= seqCnt + 16'd1;
      if (slotFree) begin
        slotBusy[freeSlot] <= 1'b0;
        freeSlot           <= ~freeSlot;
      end
      if (start) begin
        capturing          <= 1'b1;
        beatCnt            <= '0;
        slotBusy[nextSlot] <= 1'b1;
        nextSlot           <= ~nextSlot;
      end else if (capturing && delayedValid) begin
        beatCnt <= beatCnt + 4'd1;
        if (lastWrite) capturing <= 1'b0;
      end
    end
  end

  // frame payload
  always_ff @(posedge WR_CLK) begin
    if (start) begin
      curSlot  <= nextSlot;
      framePre <= preLen;
      frameTs  <= tsCnt - framePkg::TS_W'(preLen);   // first beat of the window
    end
    if (capturing && delayedValid && !beatCnt[0]) holdBeat <= delayedBeat;
  end

endmodule

/* source/framePkg.sv */
package framePkg;

  // frame geometry
  localparam int FRAME_BEATS = 16;           // beats per frame
  localparam int FRAME_WORDS = 8;            // data words per frame, two beats each
  localparam int PRE_LEN_W   = 3;            // pre-trigger length width
  localparam int TS_W        = 48;           // beat timestamp width

  localparam logic [7:0] CHANNEL_ID  = 8'd3;
  localparam logic [7:0] HEADER_MARK = 8'hA5;
  localparam logic [7:0] FOOTER_MARK = 8'h5A;

  localparam int DESC_DEPTH = 2;             // one entry per memory slot
  localparam int OUT_DEPTH  = 4;
  localparam int OUT_CNT_W  = $clog2(OUT_DEPTH + 1);

  // one ADC beat: two samples and the trigger flag
  typedef struct packed {
    logic [11:0] sampleA;
    logic [11:0] sampleB;
    logic        trig;
  } sampleBeat;

  typedef logic [63:0] frameWord;

  // descriptor of one captured frame
  typedef struct packed {
    logic [TS_W-1:0]      timeStamp;         // index of the first beat
    logic [15:0]          seqNum;
    logic [PRE_LEN_W-1:0] preLen;
    logic                 slot;
  } frameInfo;

  // single-port memory request
  typedef struct packed {
    logic       write;
    logic [3:0] addr;                        // {slot, word index}
    frameWord   wdata;
  } ramReq;

  // word layouts, msb first
  typedef struct packed {
    logic [7:0]      mark;
    logic [7:0]      channel;
    logic [TS_W-1:0] timeStamp;
  } headerWord;

  typedef struct packed {
    logic [15:0] pad;
    logic [11:0] earlyA;
    logic [11:0] earlyB;
    logic [11:0] lateA;
    logic [11:0] lateB;
  } dataWord;

  typedef struct packed {
    logic [7:0]  mark;
    logic [15:0] seqNum;
    logic [15:0] preLen;                     // value sits in low bits
    logic [23:0] pad;
  } footerWord;

endpackage

/* source/frameRam.sv */
module frameRam (
  input  logic               WR_CLK,
  input  framePkg::ramReq    req,
  input  logic               en,
  output framePkg::frameWord rdata
);

  // two slots of eight words
  framePkg::frameWord mem [16];

  always_ff @(posedge WR_CLK) begin
    if (en) begin
      if (req.write) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata <= mem[req.addr];            // registered read
      end
    end
  end

endmodule

/* source/frameRamArbiter.sv */
module frameRamArbiter (
  input  logic               WR_CLK,
  input  logic               RD_RESET,
  input  logic               wrReq,
  input  framePkg::ramReq    wrData,
  input  logic               rdReq,
  input  logic [3:0]         rdAddr,
  output logic               rdGrant,
  output logic               rdValid,
  output framePkg::frameWord rdData
);

  framePkg::ramReq memReq;
  logic memEn;

  // writes never wait, reads fill the gaps
  assign rdGrant = rdReq & ~wrReq;
  assign memEn   = wrReq | rdGrant;

  always_comb begin
    if (wrReq) begin
      memReq = wrData;
    end else begin
      memReq = '{write: 1'b0, addr: rdAddr, wdata: '0};
    end
  end

  // data of a granted read lands next cycle
  always_ff @(posedge WR_CLK) begin
    if (RD_RESET) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= rdGrant;
    end
  end

  frameRam ram (
    .WR_CLK (WR_CLK),
    .req    (memReq),
    .en     (memEn),
    .rdata  (rdData)
  );

endmodule

/* source/frameReader.sv */
module frameReader (
  input  logic                           WR_CLK,
  input  logic                           RD_RESET,
  input  logic                           descValid,
  input  framePkg::frameInfo             desc,
  output logic                           descPop,
  output logic                           rdReq,
  output logic [3:0]                     rdAddr,
  input  logic                           rdGrant,
  input  logic                           rdValid,
  input  framePkg::frameWord             rdData,
  output logic                           outPush,
  output framePkg::frameWord             outWord,
  input  logic [framePkg::OUT_CNT_W-1:0] outFree,
  output logic                           slotFree
);

  typedef enum logic [1:0] {stIdle, stHead, stData, stFoot} readState;

  readState state;
  logic [2:0] rdCnt;                       // next word index to read
  logic roomOk;
  logic headPush;
  logic footPush;
  framePkg::headerWord hdr;
  framePkg::footerWord ftr;

  assign hdr = '{mark: framePkg::HEADER_MARK, channel: framePkg::CHANNEL_ID,
                 timeStamp: desc.timeStamp};
  assign ftr = '{mark: framePkg::FOOTER_MARK, seqNum: desc.seqNum,
                 preLen: 16'(desc.preLen), pad: 24'd0};

  // a returning word takes one place this cycle, keep two spare beyond it
  assign roomOk = rdValid ? (outFree >= 3) : (outFree >= 2);

  assign headPush = (state == stHead) & (outFree >= 2);
  assign footPush = (state == stFoot) & ~rdValid & (outFree >= 2);   // last data first
  assign rdReq    = (state == stData) & roomOk;
  assign rdAddr   = {desc.slot, rdCnt};

  assign outPush = rdValid | headPush | footPush;
  assign outWord = rdValid ? rdData :
                   (state == stHead) ? framePkg::frameWord'(hdr) : framePkg::frameWord'(ftr);
  assign descPop = footPush;               // frame fully queued

  always_ff @(posedge WR_CLK) begin
    if (RD_RESET) begin
      state    <= stIdle;
      rdCnt    <= '0;
      slotFree <= 1'b0;
    end else begin
      slotFree <= footPush;                // slot released after the footer
      case (state)
        stIdle: if (descValid) state <= stHead;
        stHead: begin
          if (headPush) begin
            state <= stData;
            rdCnt <= '0;
          end
        end
        stData: begin
          if (rdReq && rdGrant) begin
            rdCnt <= rdCnt + 3'd1;
            if (rdCnt == 3'(framePkg::FRAME_WORDS - 1)) state <= stFoot;
          end
        end
        stFoot: if (footPush) state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

endmodule

/* source/preTriggerDelay.sv */
module preTriggerDelay (
  input  logic                           WR_CLK,
  input  logic                           RD_RESET,
  input  logic                           beatValid,
  input  framePkg::sampleBeat            beatIn,
  input  logic [framePkg::PRE_LEN_W-1:0] preLen,
  output framePkg::sampleBeat            delayedBeat,
  output logic                           delayedValid
);

  // 8 entries covers the longest pre-trigger window
  framePkg::sampleBeat ring [8];
  logic [2:0] wrPtr;
  logic [2:0] rdIdx;

  assign rdIdx = wrPtr - preLen;           // wraps mod 8

  always_ff @(posedge WR_CLK) begin
    if (RD_RESET) begin
      for (int i = 0; i < 8; i++) begin
        ring[i] <= '0;
      end
      wrPtr        <= '0;
      delayedBeat  <= '0;
      delayedValid <= 1'b0;
    end else begin
      delayedValid <= beatValid;           // one cycle behind the live beat
      if (beatValid) begin
        ring[wrPtr] <= beatIn;
        wrPtr       <= wrPtr + 3'd1;
        // zero length means the beat being written now
        if (preLen == '0) begin
          delayedBeat <= beatIn;
        end else begin
          delayedBeat <= ring[rdIdx];
        end
      end
    end
  end

endmodule

/* source/syncFifo.sv */
module syncFifo #(
  parameter type payload_t = logic [63:0],
  parameter int  DEPTH     = 4
) (
  input  logic                         WR_CLK,
  input  logic                         RD_RESET,
  input  logic                         push,
  input  payload_t                     din,
  input  logic                         pop,
  output payload_t                     dout,
  output logic                         notEmpty,
  output logic                         full,
  output logic [$clog2(DEPTH+1)-1:0]   freeCount
);

  payload_t mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wrPtr;
  logic [$clog2(DEPTH)-1:0] rdPtr;
  logic [$clog2(DEPTH+1)-1:0] count;       // occupancy
  logic doPush;
  logic doPop;

  assign doPush    = push & ~full;         // overflow push is dropped
  assign doPop     = pop & notEmpty;
  assign notEmpty  = (count != '0);
  assign full      = (count == ($clog2(DEPTH+1))'(DEPTH));
  assign freeCount = ($clog2(DEPTH+1))'(DEPTH) - count;
  assign dout      = mem[rdPtr];           // head shows without a pop

  always_ff @(posedge WR_CLK) begin
    if (RD_RESET) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= (wrPtr == DEPTH - 1) ? '0 : wrPtr + 1'b1;
      if (doPop) rdPtr <= (rdPtr == DEPTH - 1) ? '0 : rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge WR_CLK) begin
    if (doPush) mem[wrPtr] <= din;
  end

endmodule

/* tb/tbFrameCheck.svh */
`ifndef TB_FRAME_CHECK_SVH
`define TB_FRAME_CHECK_SVH

// data word idx of a frame whose first beat is ts
function automatic framePkg::frameWord expectedWord(input logic [47:0] ts, input int idx);
  framePkg::sampleBeat early;
  framePkg::sampleBeat late;
  early = history[int'(ts) + 2 * idx];
  late  = history[int'(ts) + 2 * idx + 1];
  return {16'h0000, early.sampleA, early.sampleB, late.sampleA, late.sampleB};
endfunction

// first accepted trigger at or after from, or -1
function automatic int nextTrigger(input int from);
  for (int t = (from < 0) ? 0 : from; t < beatCount; t++) begin
    if (history[t].trig === 1'b1) return t;
  end
  return -1;
endfunction

task automatic checkWord(input string name, input framePkg::frameWord got,
                         input framePkg::frameWord exp);
  if (got !== exp) begin
    valueErrs++;
    $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
  end
endtask

// fields decoded from header and footer
task automatic checkInfo(input string name, input framePkg::frameInfo got,
                         input framePkg::frameInfo exp);
  if (got !== exp) begin
    valueErrs++;
    $display("[FAIL] %0t %s got ts %0d seq %0d pre %0d expected ts %0d seq %0d pre %0d",
             $time, name, got.timeStamp, got.seqNum, got.preLen,
             exp.timeStamp, exp.seqNum, exp.preLen);
  end
endtask

`endif

/* tb/tbDataFrameGenerator.sv */
module tbDataFrameGenerator;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TOTAL_BEATS = 820;                               // sum over all phases
  localparam int LIMIT_NS = 16 * 4 + TOTAL_BEATS * 4 * 4 + 2000;  // plus margin

  logic WR_CLK;
  logic RD_RESET;
  logic [2:0] preLen;
  logic inValid;
  framePkg::sampleBeat inBeat;
  logic inReady;
  logic outReady;
  logic outValid;
  framePkg::frameWord outWord;

  integer seed = 32'hd72da7fd;
  int valueErrs = 0;
  int otherErrs = 0;
  int beatCount = 0;                     // timestamp of the next accepted beat
  int trigCount = 0;
  int frameCount = 0;
  int lastTrig = -16;                    // trigger of the previous frame
  int pos = 0;                           // 0 header, 1..8 data, 9 footer
  logic [47:0] hdrTs;
  logic [7:0] preSeen = '0;
  logic stalled = 1'b0;
  framePkg::frameWord heldWord;
  framePkg::sampleBeat history [1024];   // every accepted beat by timestamp
  logic [2:0] preHist [1024];            // preLen applied with that beat

  `include "tbFrameCheck.svh"

  dataFrameGenerator UUT (
    .WR_CLK (WR_CLK), .RD_RESET (RD_RESET), .preLen (preLen), .inValid (inValid),
    .inBeat (inBeat), .inReady (inReady), .outReady (outReady), .outValid (outValid),
    .outWord (outWord)
  );

  initial begin
    WR_CLK = 1'b0;
    forever #2 WR_CLK = ~WR_CLK;
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic takeWord(input framePkg::frameWord w);
    framePkg::frameInfo got;
    framePkg::frameInfo exp;
    int from;
    int trigTs;
    if (pos == 0) begin
      if (w[63:56] !== framePkg::HEADER_MARK) begin
        otherErrs++;
        $display("at %0t a frame does not start with the header marker", $time);
      end
      checkWord("outWord header", w, {framePkg::HEADER_MARK, framePkg::CHANNEL_ID, w[47:0]});
      hdrTs = w[47:0];
    end else if (pos < 9) begin
      checkWord("outWord data", w, expectedWord(hdrTs, pos - 1));
    end else begin
      if (w[63:56] !== framePkg::FOOTER_MARK) begin
        otherErrs++;
        $display("at %0t no footer marker after eight data words", $time);
      end
      checkWord("outWord footer", w, {framePkg::FOOTER_MARK, w[55:40], 13'd0, w[26:24], 24'd0});
      // triggers inside the previous capture are skipped
      from = int'(hdrTs) + int'(w[26:24]);
      if (from < lastTrig + 16) from = lastTrig + 16;
      trigTs = nextTrigger(from);
      got = '{timeStamp: hdrTs, seqNum: w[55:40], preLen: w[26:24], slot: 1'b0};
      exp = '{timeStamp: 48'(trigTs - int'(preHist[trigTs])), seqNum: 16'(frameCount),
              preLen: preHist[trigTs], slot: 1'b0};
      checkInfo("frame info", got, exp);
      lastTrig = int'(hdrTs) + int'(w[26:24]);
      preSeen[w[26:24]] = 1'b1;
      frameCount++;
    end
    pos = (pos == 9) ? 0 : pos + 1;
  endtask

  // input history, stall hold and output words
  always @(posedge WR_CLK) begin
    if (outValid && trigCount == 0) begin
      otherErrs++;
      $display("at %0t outValid went high before any trigger", $time);
    end
    if (stalled && !outValid) begin
      otherErrs++;
      $display("at %0t outValid dropped while the word was stalled", $time);
    end else if (stalled) checkWord("outWord stalled", outWord, heldWord);
    stalled  = outValid && !outReady;
    heldWord = outWord;
    if (outValid && outReady) takeWord(outWord);
    if (inValid && inReady) begin
      history[beatCount] = inBeat;
      preHist[beatCount] = preLen;
      if (inBeat.trig) trigCount++;
      beatCount++;
    end
  end

  // readyMode 0 held low, 1 held high, 2 random
  task automatic runPhase(input logic [2:0] pre, input int beats, input int trigDiv,
                          input int readyMode);
    int first;
    int idx;
    logic [31:0] rnd;
    logic [31:0] smp;
    first = beatCount;
    while (beatCount < first + beats) begin
      @(posedge WR_CLK);
      #1;
      rnd = $random(seed);
      smp = $random(seed);
      idx = beatCount - first;
      preLen = pre;
      inValid = (rnd[18:16] != 3'd0) && (beatCount < first + beats);
      inBeat.sampleA = smp[11:0];
      inBeat.sampleB = smp[27:16];
      // quiet head and tail so preLen never changes under a capture
      inBeat.trig = (trigDiv > 0) && idx >= 10 && idx < beats - 20 && (rnd[7:0] % trigDiv == 0);
      outReady = (readyMode == 2) ? rnd[20] : (readyMode == 1);
    end
  endtask

  initial begin
    RD_RESET = 1'b1;
    preLen   = '0;
    inValid  = 1'b0;
    inBeat   = '0;
    outReady = 1'b0;
    repeat (8) @(posedge WR_CLK);
    #1;
    if (inReady !== 1'b0 || outValid !== 1'b0) begin
      otherErrs++;
      $display("inReady or outValid is not low during reset");
    end
    repeat (8) @(posedge WR_CLK);
    #1;
    RD_RESET = 1'b0;
    repeat (2) @(posedge WR_CLK);
    #1;
    if (inReady !== 1'b1) begin
      otherErrs++;
      $display("inReady did not go high after reset");
    end
    runPhase(3'd0, 200, 24, 1);
    runPhase(3'd3, 200, 24, 2);
    runPhase(3'd7, 200, 4, 2);           // packed triggers
    runPhase(3'd5, 120, 6, 0);           // triggers under full back-pressure
    runPhase(3'd7, 100, 0, 1);           // drain
    while (outValid || pos != 0) begin
      @(posedge WR_CLK);
      #1;
    end
    if (!preSeen[0] || !preSeen[3] || !preSeen[7]) begin
      otherErrs++;
      $display("no frame came out for one of the preLen values 0, 3, 7");
    end
    if (frameCount >= trigCount) begin
      otherErrs++;
      $display("every trigger produced a frame, none was dropped");
    end
    $display("errors: %0d value, %0d other; %0d frames from %0d triggers",
             valueErrs, otherErrs, frameCount, trigCount);
    if (valueErrs + otherErrs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+tb
source/framePkg.sv
source/frameRam.sv
source/syncFifo.sv
source/preTriggerDelay.sv
source/frameCapture.sv
source/frameRamArbiter.sv
source/frameReader.sv
source/dataFrameGenerator.sv
tb/tbDataFrameGenerator.sv
